// ==== verilog/qr_fixed_pkg.sv ====
package qr_fixed_pkg;

    // signed q16.16 words
    localparam int WORD_BITS = 32;
    localparam int FRAC_BITS = 16;

    // matrix geometry
    localparam int LANES  = 4;      // rows, one multiplier each
    localparam int N_COLS = 4;

    // flat buses, word i+4j is row i of column j
    localparam int MAT_BITS  = WORD_BITS * LANES * N_COLS;
    localparam int NORM_BITS = WORD_BITS * N_COLS;

    // divider runs one step per dividend bit
    localparam int DIV_STEPS    = WORD_BITS + FRAC_BITS;
    localparam int DIV_CNT_BITS = $clog2(DIV_STEPS);

endpackage

// ==== verilog/qr_seq_pkg.sv ====
package qr_seq_pkg;

    // column index width
    localparam int COL_BITS = 2;

    // operand select codes for the lane muxes
    localparam int SEL_BITS = 2;

    localparam logic [SEL_BITS-1:0] OPSEL_A    = 2'd0;  // column a_k
    localparam logic [SEL_BITS-1:0] OPSEL_U    = 2'd1;  // column u_j
    localparam logic [SEL_BITS-1:0] OPSEL_COEF = 2'd2;  // coef on every lane

    // u1 = a1, so orthogonalization starts at the second column
    localparam logic [COL_BITS-1:0] FIRST_K = 2'd1;

endpackage

// ==== verilog/fx_dot_lanes.sv ====
`timescale 1ns/1ps

module fx_dot_lanes import qr_fixed_pkg::*;
(
    input  logic                       clk_QR,
    input  logic                       go_QR,
    input  logic [LANES*WORD_BITS-1:0] op_x,
    input  logic [LANES*WORD_BITS-1:0] op_y,
    output logic [LANES*WORD_BITS-1:0] prod,   // per lane, no register
    output logic [WORD_BITS-1:0]       dot     // one cycle after operands
);

    logic signed [2*WORD_BITS-1:0] full  [0:LANES-1];   // full product
    logic signed [2*WORD_BITS-1:0] align [0:LANES-1];   // back to q16.16
    logic        [WORD_BITS-1:0]   sum;

    always_comb
    begin
        sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            full[i]  = $signed(op_x[i*WORD_BITS +: WORD_BITS])
                     * $signed(op_y[i*WORD_BITS +: WORD_BITS]);
            align[i] = full[i] >>> FRAC_BITS;         // arithmetic shift
            prod[i*WORD_BITS +: WORD_BITS] = align[i][WORD_BITS-1:0];
            sum = sum + align[i][WORD_BITS-1:0];      // wraps at 32 bits
        end
    end

    // adder tree output register
    always_ff @(posedge clk_QR or negedge go_QR)
    begin
        if (!go_QR)
            dot <= '0;
        else
            dot <= sum;
    end

endmodule

// ==== verilog/proj_divider.sv ====
`timescale 1ns/1ps

module proj_divider import qr_fixed_pkg::*;
(
    input  logic                 clk_QR,
    input  logic                 go_QR,
    input  logic                 div_start,  // only while idle
    input  logic [WORD_BITS-1:0] dot,
    input  logic [WORD_BITS-1:0] divisor,
    output logic [WORD_BITS-1:0] coef,       // held until next result
    output logic                 div_done
);

    logic                    busy;
    logic [DIV_CNT_BITS-1:0] cnt;
    logic [DIV_STEPS-1:0]    quo;       // dividend shifts out, quotient shifts in
    logic [WORD_BITS:0]      rem;       // partial remainder
    logic [WORD_BITS-1:0]    dvs;       // divisor magnitude
    logic                    neg;       // result sign
    logic                    dvs_zero;
    logic [DIV_STEPS-1:0]    dvd_s;     // dot << FRAC_BITS, signed
    logic [WORD_BITS:0]      shifted;
    logic [WORD_BITS+1:0]    trial;
    logic                    fits;
    logic [DIV_STEPS-1:0]    quo_nxt;
    logic [DIV_STEPS-1:0]    q_signed;

    assign dvd_s    = {dot, {FRAC_BITS{1'b0}}};
    assign shifted  = {rem[WORD_BITS-1:0], quo[DIV_STEPS-1]};
    assign trial    = {1'b0, shifted} - {2'b00, dvs};
    assign fits     = ~trial[WORD_BITS+1];        // no borrow
    assign quo_nxt  = {quo[DIV_STEPS-2:0], fits};
    assign q_signed = neg ? -quo_nxt : quo_nxt;   // truncation toward zero

    // magnitudes and one restoring step per cycle
    always_ff @(posedge clk_QR)
    begin
        if (div_start && !busy)
        begin
            quo      <= dot[WORD_BITS-1] ? -dvd_s : dvd_s;
            rem      <= '0;
            dvs      <= divisor[WORD_BITS-1] ? -divisor : divisor;
            neg      <= dot[WORD_BITS-1] ^ divisor[WORD_BITS-1];
            dvs_zero <= (divisor == '0);
        end
        else if (busy)
        begin
            rem <= fits ? trial[WORD_BITS:0] : shifted;   // restore on borrow
            quo <= quo_nxt;
        end
    end

    always_ff @(posedge clk_QR or negedge go_QR)
    begin
        if (!go_QR)
        begin
            busy     <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
            coef     <= '0;
        end
        else
        begin
            div_done <= 1'b0;
            if (div_start && !busy)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (busy)
            begin
                cnt <= cnt + DIV_CNT_BITS'(1);
                if (cnt == DIV_CNT_BITS'(DIV_STEPS - 1))   // last step
                begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                    coef     <= dvs_zero ? '0 : q_signed[WORD_BITS-1:0];
                end
            end
        end
    end

endmodule

// ==== verilog/column_store.sv ====
`timescale 1ns/1ps

module column_store import qr_fixed_pkg::*, qr_seq_pkg::*;
(
    input  logic                       clk_QR,
    input  logic                       go_QR,
    input  logic [MAT_BITS-1:0]        c_in,
    input  logic                       load,
    input  logic                       upd,
    input  logic                       norm_wr,
    input  logic [COL_BITS-1:0]        col_k,
    input  logic [COL_BITS-1:0]        col_j,
    input  logic [SEL_BITS-1:0]        x_sel,
    input  logic [SEL_BITS-1:0]        y_sel,
    input  logic [LANES*WORD_BITS-1:0] prod,
    input  logic [WORD_BITS-1:0]       dot,
    input  logic [WORD_BITS-1:0]       coef,
    output logic [LANES*WORD_BITS-1:0] op_x,
    output logic [LANES*WORD_BITS-1:0] op_y,
    output logic [WORD_BITS-1:0]       divisor,
    output logic [MAT_BITS-1:0]        u_out,
    output logic [NORM_BITS-1:0]       norm_out
);

    logic [WORD_BITS-1:0] a_mem [0:N_COLS-1][0:LANES-1];  // input columns
    logic [WORD_BITS-1:0] u_mem [0:N_COLS-1][0:LANES-1];  // orthogonal columns
    logic [WORD_BITS-1:0] norm_mem [0:N_COLS-1];          // squared norms

    // lane operand mux, same for x and y
    function automatic logic [WORD_BITS-1:0] pick(
        input logic [SEL_BITS-1:0]  sel,
        input logic [WORD_BITS-1:0] a_w,
        input logic [WORD_BITS-1:0] u_w,
        input logic [WORD_BITS-1:0] c_w
    );
        case (sel)
            OPSEL_A:    return a_w;
            OPSEL_U:    return u_w;
            OPSEL_COEF: return c_w;   // broadcast
            default:    return '0;
        endcase
    endfunction

    always_ff @(posedge clk_QR)
    begin
        if (load)
            for (int c = 0; c < N_COLS; c++)
                for (int r = 0; r < LANES; r++)
                    a_mem[c][r] <= c_in[(r + LANES*c)*WORD_BITS +: WORD_BITS];
    end

    always_ff @(posedge clk_QR or negedge go_QR)
    begin
        if (!go_QR)
        begin
            for (int c = 0; c < N_COLS; c++)
            begin
                norm_mem[c] <= '0;
                for (int r = 0; r < LANES; r++)
                    u_mem[c][r] <= '0;
            end
        end
        else
        begin
            if (load)       // u starts as a copy of a
                for (int c = 0; c < N_COLS; c++)
                    for (int r = 0; r < LANES; r++)
                        u_mem[c][r] <= c_in[(r + LANES*c)*WORD_BITS +: WORD_BITS];
            if (upd)        // u_k -= coef * u_j
                for (int r = 0; r < LANES; r++)
                    u_mem[col_k][r] <= u_mem[col_k][r] - prod[r*WORD_BITS +: WORD_BITS];
            if (norm_wr)
                norm_mem[col_j] <= dot;
        end
    end

    always_comb
    begin
        for (int r = 0; r < LANES; r++)
        begin
            op_x[r*WORD_BITS +: WORD_BITS] = pick(x_sel, a_mem[col_k][r], u_mem[col_j][r], coef);
            op_y[r*WORD_BITS +: WORD_BITS] = pick(y_sel, a_mem[col_k][r], u_mem[col_j][r], coef);
        end
        for (int c = 0; c < N_COLS; c++)
        begin
            norm_out[c*WORD_BITS +: WORD_BITS] = norm_mem[c];
            for (int r = 0; r < LANES; r++)
                u_out[(r + LANES*c)*WORD_BITS +: WORD_BITS] = u_mem[c][r];
        end
    end

    assign divisor = norm_mem[col_j];   // norm of the column being projected

endmodule

// ==== verilog/gs_sequencer.sv ====
`timescale 1ns/1ps

module gs_sequencer import qr_fixed_pkg::*, qr_seq_pkg::*;
(
    input  logic                clk_QR,
    input  logic                go_QR,      // async reset, active low
    input  logic                div_done,   // one-cycle pulse from divider
    output logic                load,
    output logic                upd,
    output logic                norm_wr,
    output logic                div_start,
    output logic [COL_BITS-1:0] col_k,
    output logic [COL_BITS-1:0] col_j,
    output logic [SEL_BITS-1:0] x_sel,
    output logic [SEL_BITS-1:0] y_sel,
    output logic                done
);

    // fsm states
    localparam logic [3:0] S_IDLE     = 4'd0;
    localparam logic [3:0] S_LOAD     = 4'd1;
    localparam logic [3:0] S_NORM_OP  = 4'd2;   // u_j . u_j on the lanes
    localparam logic [3:0] S_NORM_WR  = 4'd3;
    localparam logic [3:0] S_DOT_OP   = 4'd4;   // u_j . a_k on the lanes
    localparam logic [3:0] S_DIV_GO   = 4'd5;
    localparam logic [3:0] S_DIV_WAIT = 4'd6;
    localparam logic [3:0] S_UPD      = 4'd7;
    localparam logic [3:0] S_FIN_OP   = 4'd8;   // norm of the last column
    localparam logic [3:0] S_FIN_WR   = 4'd9;
    localparam logic [3:0] S_DONE     = 4'd10;

    logic [3:0]          state;
    logic [COL_BITS-1:0] k;         // column being orthogonalized
    logic [COL_BITS-1:0] j;         // column projected out of k
    logic                last_j;
    logic                last_k;

    // j = k-1 means u_j is final, so its norm is due
    assign last_j = (j == k - COL_BITS'(1));
    assign last_k = (k == COL_BITS'(N_COLS - 1));

    always_ff @(posedge clk_QR or negedge go_QR)
    begin
        if (!go_QR)
        begin
            state <= S_IDLE;
            k     <= FIRST_K;
            j     <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:     state <= S_LOAD;
                S_LOAD:     state <= last_j ? S_NORM_OP : S_DOT_OP;
                S_NORM_OP:  state <= S_NORM_WR;     // dot valid next cycle
                S_NORM_WR:  state <= S_DOT_OP;
                S_DOT_OP:   state <= S_DIV_GO;
                S_DIV_GO:   state <= S_DIV_WAIT;    // divider latches dot here
                S_DIV_WAIT:
                begin
                    if (div_done)
                        state <= S_UPD;
                end
                S_UPD:
                begin
                    if (last_j && last_k)
                    begin
                        j     <= COL_BITS'(N_COLS - 1);   // point at u4
                        state <= S_FIN_OP;
                    end
                    else if (last_j)
                    begin
                        k     <= k + COL_BITS'(1);
                        j     <= '0;
                        state <= S_DOT_OP;  // norm 1 already stored
                    end
                    else
                    begin
                        j     <= j + COL_BITS'(1);
                        // next j may be the final one for this k
                        state <= (j + COL_BITS'(2) == k) ? S_NORM_OP : S_DOT_OP;
                    end
                end
                S_FIN_OP:   state <= S_FIN_WR;
                S_FIN_WR:   state <= S_DONE;
                S_DONE:     state <= S_DONE;        // hold until reset
                default:    state <= S_IDLE;
            endcase
        end
    end

    // strobes and operand selects decoded from state
    always_comb
    begin
        load      = 1'b0;
        upd       = 1'b0;
        norm_wr   = 1'b0;
        div_start = 1'b0;
        done      = 1'b0;
        x_sel     = OPSEL_U;
        y_sel     = OPSEL_U;
        case (state)
            S_LOAD:     load = 1'b1;
            S_NORM_WR:  norm_wr = 1'b1;
            S_DOT_OP:   y_sel = OPSEL_A;
            S_DIV_GO:
            begin
                y_sel     = OPSEL_A;
                div_start = 1'b1;
            end
            S_DIV_WAIT: x_sel = OPSEL_COEF;  // coef times u_j lanes
            S_UPD:
            begin
                x_sel = OPSEL_COEF;
                upd   = 1'b1;
            end
            S_FIN_WR:   norm_wr = 1'b1;
            S_DONE:     done = 1'b1;
            default:    ;
        endcase
    end

    assign col_k = k;
    assign col_j = j;

endmodule

// ==== verilog/qr_top.sv ====
`timescale 1ns/1ps

module qr_top import qr_fixed_pkg::*, qr_seq_pkg::*;
(
    input  logic                 clk_QR,
    input  logic                 go_QR,      // async reset, active low
    input  logic [MAT_BITS-1:0]  c_in,       // held until done
    output logic [MAT_BITS-1:0]  u_out,
    output logic [NORM_BITS-1:0] norm_out,
    output logic                 done
);

    // sequencer strobes
    logic                       load;
    logic                       upd;
    logic                       norm_wr;
    logic                       div_start;
    logic                       div_done;
    logic [COL_BITS-1:0]        col_k;
    logic [COL_BITS-1:0]        col_j;
    logic [SEL_BITS-1:0]        x_sel;
    logic [SEL_BITS-1:0]        y_sel;

    // datapath
    logic [LANES*WORD_BITS-1:0] op_x;
    logic [LANES*WORD_BITS-1:0] op_y;
    logic [LANES*WORD_BITS-1:0] prod;      // per-lane fxmul, combinational
    logic [WORD_BITS-1:0]       dot;       // registered lane sum
    logic [WORD_BITS-1:0]       coef;
    logic [WORD_BITS-1:0]       divisor;   // norm of column j

    gs_sequencer u_seq (
        .clk_QR(clk_QR), .go_QR(go_QR), .div_done(div_done),
        .load(load), .upd(upd), .norm_wr(norm_wr), .div_start(div_start),
        .col_k(col_k), .col_j(col_j), .x_sel(x_sel), .y_sel(y_sel), .done(done)
    );

    column_store u_store (
        .clk_QR(clk_QR), .go_QR(go_QR), .c_in(c_in),
        .load(load), .upd(upd), .norm_wr(norm_wr),
        .col_k(col_k), .col_j(col_j), .x_sel(x_sel), .y_sel(y_sel),
        .prod(prod), .dot(dot), .coef(coef),
        .op_x(op_x), .op_y(op_y), .divisor(divisor),
        .u_out(u_out), .norm_out(norm_out)
    );

    fx_dot_lanes u_lanes (
        .clk_QR(clk_QR), .go_QR(go_QR), .op_x(op_x), .op_y(op_y),
        .prod(prod), .dot(dot)
    );

    proj_divider u_div (
        .clk_QR(clk_QR), .go_QR(go_QR), .div_start(div_start),
        .dot(dot), .divisor(divisor), .coef(coef), .div_done(div_done)
    );

endmodule

// ==== verification/qr_top_asserts.sv ====
`timescale 1ns/1ps

module qr_top_asserts import qr_fixed_pkg::*;
(
    input logic                 clk_QR,
    input logic                 go_QR,
    input logic                 done,
    input logic [MAT_BITS-1:0]  u_out,
    input logic [NORM_BITS-1:0] norm_out,
    input logic                 div_start,
    input logic                 div_done
);

    logic in_div;               // from div_start up to div_done
    logic any_fail = 1'b0;      // sticky, set by any failing property

    always_ff @(posedge clk_QR or negedge go_QR)
    begin
        if (!go_QR)
            in_div <= 1'b0;
        else if (div_start)
            in_div <= 1'b1;
        else if (div_done)
            in_div <= 1'b0;
    end

    done_low_in_reset: assert property (@(posedge clk_QR) !go_QR |-> !done)
    else begin $error("done high while go_QR is low"); any_fail = 1'b1; end

    done_holds: assert property (@(posedge clk_QR) disable iff (!go_QR) done |=> done)
    else begin $error("done fell without a reset"); any_fail = 1'b1; end

    result_stable: assert property (@(posedge clk_QR) disable iff (!go_QR)
        done |=> ($stable(u_out) && $stable(norm_out)))
    else begin $error("u_out or norm_out moved while done"); any_fail = 1'b1; end

    no_start_when_busy: assert property (@(posedge clk_QR) disable iff (!go_QR)
        div_start |-> !in_div)
    else begin $error("div_start during a division"); any_fail = 1'b1; end

endmodule

bind qr_top qr_top_asserts u_chk (
    .clk_QR(clk_QR), .go_QR(go_QR), .done(done), .u_out(u_out),
    .norm_out(norm_out), .div_start(div_start), .div_done(div_done)
);

// ==== verification/tb_qr_top.sv ====
`timescale 1ns/1ps

module tb_qr_top import qr_fixed_pkg::*;
();

    localparam int                   DONE_TIMEOUT = 2000;   // cycles of margin over one run
    localparam logic [WORD_BITS-1:0] ONE = WORD_BITS'(1 <<< FRAC_BITS);   // 1.0

    logic                 clk_QR;
    logic                 go_QR;
    logic [MAT_BITS-1:0]  c_in;
    logic [MAT_BITS-1:0]  u_out;
    logic [NORM_BITS-1:0] norm_out;
    logic                 done;

    // model columns by [column][row]
    logic [WORD_BITS-1:0] m_a [0:N_COLS-1][0:LANES-1];
    logic [WORD_BITS-1:0] m_u [0:N_COLS-1][0:LANES-1];
    logic [WORD_BITS-1:0] m_n [0:N_COLS-1];

    qr_top u_dut (
        .clk_QR(clk_QR), .go_QR(go_QR), .c_in(c_in),
        .u_out(u_out), .norm_out(norm_out), .done(done)
    );

    initial
    begin
        clk_QR = 1'b0;
        forever #20 clk_QR = ~clk_QR;   // 40 ns period
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic step();      // 2 ns past the next rising edge
        @(posedge clk_QR);
        #2;
    endtask

    // q16.16 multiply as full product then arithmetic shift
    function automatic logic [WORD_BITS-1:0] fxmul(input logic [WORD_BITS-1:0] x,
                                                   input logic [WORD_BITS-1:0] y);
        longint p;
        p = longint'($signed(x)) * longint'($signed(y));
        return WORD_BITS'(p >>> FRAC_BITS);
    endfunction

    // u_j against a_k or u_k with 32-bit wraparound
    function automatic logic [WORD_BITS-1:0] model_dot(input int j, input int k, input bit with_a);
        logic [WORD_BITS-1:0] s;
        s = '0;
        for (int r = 0; r < LANES; r++)
            s += fxmul(m_u[j][r], with_a ? m_a[k][r] : m_u[k][r]);
        return s;
    endfunction

    function automatic logic [WORD_BITS-1:0] model_coef(input logic [WORD_BITS-1:0] d,
                                                        input logic [WORD_BITS-1:0] n);
        longint num;
        longint den;
        if (n == '0)
            return '0;                                      // zero norm gives zero coef
        num = longint'($signed({d, {FRAC_BITS{1'b0}}}));    // 48-bit dividend
        den = longint'($signed(n));
        return WORD_BITS'(num / den);                       // truncates toward zero
    endfunction

    task automatic run_model(input logic [MAT_BITS-1:0] m);
        logic [WORD_BITS-1:0] cf;
        for (int c = 0; c < N_COLS; c++)
            for (int r = 0; r < LANES; r++)
            begin
                m_a[c][r] = m[(r + LANES*c)*WORD_BITS +: WORD_BITS];
                m_u[c][r] = m_a[c][r];
            end
        for (int k = 1; k < N_COLS; k++)
            for (int j = 0; j < k; j++)
            begin
                if (j == k - 1)
                    m_n[j] = model_dot(j, j, 1'b0);     // u_j final here
                cf = model_coef(model_dot(j, k, 1'b1), m_n[j]);
                for (int r = 0; r < LANES; r++)
                    m_u[k][r] -= fxmul(cf, m_u[j][r]);
            end
        m_n[N_COLS-1] = model_dot(N_COLS-1, N_COLS-1, 1'b0);
    endtask

    task automatic check_results();
        logic [WORD_BITS-1:0] got;
        for (int c = 0; c < N_COLS; c++)
        begin
            got = norm_out[c*WORD_BITS +: WORD_BITS];
            assert (got == m_n[c])
            else fail_now($sformatf("ERROR at %0t: norm_out[%0d] is %h, expected %h",
                                    $time, c, got, m_n[c]));
            for (int r = 0; r < LANES; r++)
            begin
                got = u_out[(r + LANES*c)*WORD_BITS +: WORD_BITS];
                assert (got == m_u[c][r])
                else fail_now($sformatf("ERROR at %0t: u_out[%0d] is %h, expected %h",
                                        $time, r + LANES*c, got, m_u[c][r]));
            end
        end
        assert (!u_dut.u_chk.any_fail)
        else fail_now("a bound protocol assertion on qr_top failed");
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done)
        begin
            step();
            n++;
            if (n > DONE_TIMEOUT)
                fail_now("timeout: done never rose after reset was released");
        end
    endtask

    // run from a fresh reset and check that the result holds
    task automatic run_case(input logic [MAT_BITS-1:0] m);
        c_in  = m;
        go_QR = 1'b0;
        run_model(m);
        repeat (4)
        begin
            step();
            assert (!done) else fail_now("done is high during reset");
        end
        go_QR = 1'b1;
        wait_done();
        check_results();
        repeat (3)
        begin
            step();
            assert (done) else fail_now("done dropped before the next reset");
        end
        check_results();
    endtask

    function automatic logic [MAT_BITS-1:0] rand_matrix();
        logic [MAT_BITS-1:0] m;
        int v;
        for (int w = 0; w < LANES*N_COLS; w++)
        begin
            v = int'($urandom_range(16, 0)) - 8;                // integer -8..8
            m[w*WORD_BITS +: WORD_BITS] = WORD_BITS'(v <<< FRAC_BITS);
        end
        return m;
    endfunction

    initial
    begin
        logic [MAT_BITS-1:0] m;
        void'($urandom(39));
        go_QR = 1'b0;
        c_in  = '0;

        m = '0;                                                 // identity
        for (int c = 0; c < N_COLS; c++)
            m[(c + LANES*c)*WORD_BITS +: WORD_BITS] = ONE;
        run_case(m);

        repeat (20)
            run_case(rand_matrix());

        m = rand_matrix();                                      // a2 copies a1
        for (int r = 0; r < LANES; r++)
        begin
            m[r*WORD_BITS +: WORD_BITS]           = WORD_BITS'((r + 1) <<< FRAC_BITS);
            m[(r + LANES)*WORD_BITS +: WORD_BITS] = WORD_BITS'((r + 1) <<< FRAC_BITS);
        end
        run_case(m);
        assert (norm_out[WORD_BITS +: WORD_BITS] == '0 && u_out[LANES*WORD_BITS +: 128] == '0)
        else fail_now($sformatf("ERROR at %0t: norm_out[1] is %h and u2 is %h, expected zero",
                                $time, norm_out[WORD_BITS +: WORD_BITS],
                                u_out[LANES*WORD_BITS +: 128]));

        c_in  = rand_matrix();                                  // reset cut into a run
        go_QR = 1'b0;
        repeat (4) step();
        go_QR = 1'b1;
        repeat (120) step();                                    // inside the third divide
        assert (!done) else fail_now("done rose before the run could have finished");
        go_QR = 1'b0;
        step();
        assert (!done) else fail_now("done is high right after reset was pulled");
        run_case(rand_matrix());

        if (u_dut.u_chk.any_fail)
            fail_now("a bound protocol assertion on qr_top failed");
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
verilog/qr_fixed_pkg.sv
verilog/qr_seq_pkg.sv
verilog/fx_dot_lanes.sv
verilog/proj_divider.sv
verilog/column_store.sv
verilog/gs_sequencer.sv
verilog/qr_top.sv
verification/qr_top_asserts.sv
verification/tb_qr_top.sv

// ==== Makefile ====
TOP = tb_qr_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f flist.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
